//--- Bender.yml
package:
  name: w0rm_decode

export_include_dirs:
  - rtl

sources:
  - rtl/w0rm_decode_pkg.sv
  - rtl/inst_predecode_reg.sv
  - rtl/operand_decode.sv
  - rtl/control_decode.sv
  - rtl/w0rm_decode.sv
  - target: test
    files:
      - tests/decode_properties.sv
      - tests/decode_tb.sv

//--- rtl/control_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "w0rm_decode_consts.svh"

module control_decode
  import w0rm_decode_pkg::*;
(
  input  inst_t        held_inst,
  input  word_t        held_addr,
  input  inst_class_t  inst_class,
  output alu_ctrl_t    alu,
  output branch_ctrl_t branch,
  output mem_ctrl_t    mem,
  output wb_ctrl_t     wb
);

  logic src_bit;
  logic mode_bit;
  logic sub_bit;

  // Bit meaning depends on class, see the cases below
  assign src_bit  = held_inst[`W0RM_FIELD_SRC];
  assign mode_bit = held_inst[`W0RM_FIELD_MODE];
  assign sub_bit  = held_inst[`W0RM_FIELD_SUB];

  always_comb
  begin
    alu    = '0;
    branch = '0;
    mem    = '0;
    wb     = '0;

    case (inst_class)
      `W0RM_CLASS_EXT:
      begin
        alu.op2_literal = `W0RM_OP2_REG;
        alu.ext_16      = sub_bit;
        alu.opcode      = mode_bit ? `W0RM_ALU_ZEX : `W0RM_ALU_SEX;
        wb.reg_write    = 1'b1;
        wb.source       = `W0RM_WB_SRC_ALU;
        wb.addr         = held_inst[7:4];
      end

      `W0RM_CLASS_MOV:
      begin
        alu.op2_literal = src_bit ? `W0RM_OP2_LIT : `W0RM_OP2_REG;
        alu.opcode      = `W0RM_ALU_MOV;
        wb.reg_write    = 1'b1;
        wb.source       = `W0RM_WB_SRC_ALU;
        wb.addr         = held_inst[11:8];
      end

      `W0RM_CLASS_ALU:
      begin
        alu.op2_literal = src_bit ? `W0RM_OP2_REG : `W0RM_OP2_LIT;
        alu.opcode      = held_inst[11:8];
        alu.store_flags = '1;
        wb.reg_write    = 1'b1;
        wb.source       = `W0RM_WB_SRC_ALU;
        wb.addr         = held_inst[7:4];
      end

      // Shift type in 7:6 offsets from LSR
      `W0RM_CLASS_SHIFT:
      begin
        alu.op2_literal = src_bit ? `W0RM_OP2_REG : `W0RM_OP2_LIT;
        alu.opcode      = `W0RM_ALU_LSR + alu_opcode_t'(held_inst[7:6]);
        alu.store_flags = '1;
        wb.reg_write    = 1'b1;
        wb.source       = `W0RM_WB_SRC_ALU;
        wb.addr         = held_inst[11:8];
      end

      `W0RM_CLASS_LDSTR:
      begin
        alu.op2_literal = `W0RM_OP2_LIT;
        alu.opcode      = `W0RM_ALU_ADD;
        mem.write       = src_bit;
        mem.read        = !src_bit;
        mem.data_src    = `W0RM_MEM_DATA_RN;
        mem.addr_src    = `W0RM_MEM_ADDR_ALU;
        wb.reg_write    = !src_bit;
        wb.source       = `W0RM_WB_SRC_MEM;
        wb.addr         = held_inst[11:8];
      end

      // Push predecrements the stack pointer, pop reads at the old one
      `W0RM_CLASS_PUPO:
      begin
        alu.op2_literal = `W0RM_OP2_LIT;
        alu.opcode      = mode_bit ? `W0RM_ALU_ADD : `W0RM_ALU_SUB;
        mem.write       = !mode_bit;
        mem.read        = mode_bit;
        mem.is_pop      = mode_bit;
        mem.data_src    = `W0RM_MEM_DATA_RN;
        mem.addr_src    = mode_bit ? `W0RM_MEM_ADDR_RN : `W0RM_MEM_ADDR_ALU;
        wb.reg_write    = mode_bit;
        wb.source       = `W0RM_WB_SRC_MEM;
        wb.addr         = held_inst[3:0];
      end

      `W0RM_CLASS_BCOND:
      begin
        alu.op2_literal  = src_bit ? `W0RM_OP2_REG : `W0RM_OP2_LIT;
        alu.opcode       = `W0RM_ALU_MOV;
        branch.is_branch = 1'b1;
        branch.is_cond   = 1'b1;
        branch.code      = held_inst[10:8];
        branch.base_addr = held_addr;
        wb.reg_write     = mode_bit;
        wb.source        = `W0RM_WB_SRC_BRANCH;
        wb.addr          = `W0RM_REG_LINK;
      end

      // Source select moves to bit 11 and link to bit 10
      `W0RM_CLASS_BUNCOND:
      begin
        alu.op2_literal  = mode_bit ? `W0RM_OP2_REG : `W0RM_OP2_LIT;
        alu.opcode       = `W0RM_ALU_MOV;
        branch.is_branch = 1'b1;
        branch.base_addr = held_addr;
        wb.reg_write     = sub_bit;
        wb.source        = `W0RM_WB_SRC_BRANCH;
        wb.addr          = `W0RM_REG_LINK;
      end

      // NOP and reserved codes never leave the stage
      default:
      begin
        alu.opcode = `W0RM_ALU_AND;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/inst_predecode_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "w0rm_decode_consts.svh"

module inst_predecode_reg
  import w0rm_decode_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        flush,
  input  logic        in_valid,
  input  inst_t       instruction,
  input  word_t       inst_addr,
  input  logic        out_ready,
  output logic        in_ready,
  output inst_t       held_inst,
  output word_t       held_addr,
  output inst_class_t inst_class,
  output logic        out_valid
);

  logic        valid_q;
  logic        invalid;
  inst_class_t top_field;

  // Slot is free when empty, holding an invalid code, or being taken downstream
  assign in_ready  = !out_valid || out_ready;
  assign out_valid = valid_q && !invalid;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      valid_q <= 1'b0;
    else if (flush)
      valid_q <= 1'b0;
    else if (in_ready)
      valid_q <= in_valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_valid && in_ready)
    begin
      held_inst <= instruction;
      held_addr <= inst_addr;
    end
  end

  assign top_field = held_inst[`W0RM_FIELD_CLASS_HI:`W0RM_FIELD_CLASS_LO];

  // NOP/EXT and PUPO/BUNCOND need all four bits, the rest only three
  always_comb
  begin
    if (top_field == `W0RM_CLASS_NOP || top_field == `W0RM_CLASS_EXT ||
        top_field == `W0RM_CLASS_PUPO || top_field == `W0RM_CLASS_BUNCOND)
      inst_class = top_field;
    else
      inst_class = {top_field[3:1], 1'b0};
  end

  assign invalid = (inst_class == `W0RM_CLASS_NOP) || (inst_class == `W0RM_CLASS_RES);

endmodule

`default_nettype wire

//--- rtl/operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "w0rm_decode_consts.svh"

module operand_decode
  import w0rm_decode_pkg::*;
(
  input  inst_t       held_inst,
  input  inst_class_t inst_class,
  output rf_ctrl_t    rf
);

  word_t lit_sext8;
  word_t lit_sext10;
  word_t lit_zext4;
  word_t lit_zext5;
  word_t lit_zext8;

  // Literal candidates, picked by class below
  assign lit_sext8  = {{24{held_inst[7]}}, held_inst[7:0]};
  assign lit_sext10 = {{22{held_inst[9]}}, held_inst[9:0]};
  assign lit_zext4  = {28'd0, held_inst[3:0]};
  assign lit_zext5  = {27'd0, held_inst[4:0]};
  assign lit_zext8  = {24'd0, held_inst[7:0]};

  always_comb
  begin
    rf = '0;

    case (inst_class)
      `W0RM_CLASS_EXT:
      begin
        rf.rd_addr = held_inst[7:4];
      end
      `W0RM_CLASS_MOV:
      begin
        rf.rn_addr = held_inst[3:0];
        rf.literal = lit_zext8;
      end
      `W0RM_CLASS_ALU:
      begin
        rf.rd_addr = held_inst[7:4];
        rf.rn_addr = held_inst[3:0];
        rf.literal = lit_zext4;
      end
      `W0RM_CLASS_SHIFT:
      begin
        rf.rd_addr = held_inst[11:8];
        rf.rn_addr = held_inst[3:0];
        rf.literal = lit_zext5;
      end
      // Base register sits in 7:4, data register in 11:8
      `W0RM_CLASS_LDSTR:
      begin
        rf.rd_addr = held_inst[7:4];
        rf.rn_addr = held_inst[11:8];
        rf.literal = lit_zext4;
      end
      `W0RM_CLASS_PUPO:
      begin
        rf.rd_addr = `W0RM_REG_STACK;
        rf.rn_addr = held_inst[3:0];
        rf.literal = `W0RM_PUPO_STEP;
      end
      `W0RM_CLASS_BCOND:
      begin
        rf.rn_addr = held_inst[3:0];
        rf.literal = lit_sext8;
      end
      `W0RM_CLASS_BUNCOND:
      begin
        rf.rn_addr = held_inst[3:0];
        rf.literal = lit_sext10;
      end
      default:
      begin
        rf = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/w0rm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_decode
  import w0rm_decode_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         flush,
  input  logic         in_valid,
  input  inst_t        instruction,
  input  word_t        inst_addr,
  input  logic         out_ready,
  output logic         in_ready,
  output logic         out_valid,
  output rf_ctrl_t     rf,
  output alu_ctrl_t    alu,
  output branch_ctrl_t branch,
  output mem_ctrl_t    mem,
  output wb_ctrl_t     wb
);

  inst_t       held_inst;
  word_t       held_addr;
  inst_class_t inst_class;

  inst_predecode_reg u_predecode (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .in_valid    (in_valid),
    .instruction (instruction),
    .inst_addr   (inst_addr),
    .out_ready   (out_ready),
    .in_ready    (in_ready),
    .held_inst   (held_inst),
    .held_addr   (held_addr),
    .inst_class  (inst_class),
    .out_valid   (out_valid)
  );

  operand_decode u_operand (
    .held_inst  (held_inst),
    .inst_class (inst_class),
    .rf         (rf)
  );

  control_decode u_control (
    .held_inst  (held_inst),
    .held_addr  (held_addr),
    .inst_class (inst_class),
    .alu        (alu),
    .branch     (branch),
    .mem        (mem),
    .wb         (wb)
  );

endmodule

`default_nettype wire

//--- rtl/w0rm_decode_consts.svh
`ifndef W0RM_DECODE_CONSTS_SVH
`define W0RM_DECODE_CONSTS_SVH

// Widths
`define W0RM_INST_WIDTH        16
`define W0RM_DATA_WIDTH        32
`define W0RM_REG_ADDR_WIDTH    4
`define W0RM_CLASS_WIDTH       4
`define W0RM_ALU_OP_WIDTH      4
`define W0RM_FLAG_WIDTH        4
`define W0RM_BRANCH_CODE_WIDTH 3
`define W0RM_SEL_WIDTH         2

// Instruction fields shared by several classes
`define W0RM_FIELD_CLASS_HI    15
`define W0RM_FIELD_CLASS_LO    12
`define W0RM_FIELD_SRC         12
`define W0RM_FIELD_MODE        11
`define W0RM_FIELD_SUB         10

// Three-bit classes are kept with bit 0 cleared
`define W0RM_CLASS_NOP         4'b0000
`define W0RM_CLASS_EXT         4'b0001
`define W0RM_CLASS_BCOND       4'b0010
`define W0RM_CLASS_MOV         4'b0100
`define W0RM_CLASS_LDSTR       4'b0110
`define W0RM_CLASS_ALU         4'b1000
`define W0RM_CLASS_SHIFT       4'b1010
`define W0RM_CLASS_RES         4'b1100
`define W0RM_CLASS_PUPO        4'b1110
`define W0RM_CLASS_BUNCOND     4'b1111

`define W0RM_ALU_AND           4'h0
`define W0RM_ALU_ADD           4'h8
`define W0RM_ALU_SUB           4'h9
`define W0RM_ALU_SEX           4'ha
`define W0RM_ALU_ZEX           4'hb
`define W0RM_ALU_LSR           4'hc
`define W0RM_ALU_MOV           4'hf

`define W0RM_REG_STACK         4'd13
`define W0RM_REG_LINK          4'd14
`define W0RM_PUPO_STEP         32'd4

`define W0RM_WB_SRC_ALU        2'd0
`define W0RM_WB_SRC_MEM        2'd1
`define W0RM_WB_SRC_BRANCH     2'd2
`define W0RM_MEM_DATA_RN       2'd0
`define W0RM_MEM_ADDR_ALU      2'd0
`define W0RM_MEM_ADDR_RN       2'd1
`define W0RM_OP2_REG           1'b0
`define W0RM_OP2_LIT           1'b1

`endif

//--- rtl/w0rm_decode_pkg.sv
`default_nettype none

`include "w0rm_decode_consts.svh"

package w0rm_decode_pkg;

  typedef logic [`W0RM_INST_WIDTH-1:0]        inst_t;
  typedef logic [`W0RM_DATA_WIDTH-1:0]        word_t;
  typedef logic [`W0RM_REG_ADDR_WIDTH-1:0]    reg_addr_t;
  typedef logic [`W0RM_CLASS_WIDTH-1:0]       inst_class_t;
  typedef logic [`W0RM_ALU_OP_WIDTH-1:0]      alu_opcode_t;
  typedef logic [`W0RM_FLAG_WIDTH-1:0]        flag_mask_t;
  typedef logic [`W0RM_BRANCH_CODE_WIDTH-1:0] branch_code_t;
  typedef logic [`W0RM_SEL_WIDTH-1:0]         sel2_t;

  // Register fetch stage
  typedef struct packed {
    reg_addr_t rd_addr;
    reg_addr_t rn_addr;
    word_t     literal;
  } rf_ctrl_t;

  // ALU stage
  typedef struct packed {
    logic        op2_literal;
    logic        ext_16;
    alu_opcode_t opcode;
    flag_mask_t  store_flags;
  } alu_ctrl_t;

  // Branch stage
  typedef struct packed {
    logic         is_branch;
    logic         is_cond;
    branch_code_t code;
    word_t        base_addr;
  } branch_ctrl_t;

  // Memory stage
  typedef struct packed {
    logic  write;
    logic  read;
    logic  is_pop;
    sel2_t data_src;
    sel2_t addr_src;
  } mem_ctrl_t;

  // Register write-back stage
  typedef struct packed {
    logic      reg_write;
    sel2_t     source;
    reg_addr_t addr;
  } wb_ctrl_t;

endpackage

`default_nettype wire

//--- sources.f
+incdir+rtl
rtl/w0rm_decode_pkg.sv
rtl/inst_predecode_reg.sv
rtl/operand_decode.sv
rtl/control_decode.sv
rtl/w0rm_decode.sv
tests/decode_properties.sv
tests/decode_tb.sv

//--- tests/decode_properties.sv
`timescale 1ns/1ps
`default_nettype none

module decode_properties
  import w0rm_decode_pkg::*;
(
  input logic         clk,
  input logic         arst_n,
  input logic         flush,
  input logic         in_ready,
  input logic         out_valid,
  input logic         out_ready,
  input rf_ctrl_t     rf,
  input alu_ctrl_t    alu,
  input branch_ctrl_t branch,
  input mem_ctrl_t    mem,
  input wb_ctrl_t     wb
);

  int fail_count = 0;

  // A stalled output keeps every control field
  a_held_stable: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready && !flush |=> out_valid && $stable(rf) && $stable(alu) &&
      $stable(branch) && $stable(mem) && $stable(wb))
    else
    begin
      fail_count++;
      $error("Held output changed under back-pressure");
    end

  a_ready_when_empty: assert property (@(posedge clk) disable iff (!arst_n)
    !out_valid |-> in_ready)
    else
    begin
      fail_count++;
      $error("in_ready low while no instruction is presented");
    end

  a_mem_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !(mem.write && mem.read))
    else
    begin
      fail_count++;
      $error("Memory read and write set together");
    end

  a_flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> !out_valid)
    else
    begin
      fail_count++;
      $error("out_valid high one cycle after flush");
    end

endmodule

`default_nettype wire

//--- tests/decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_tb
  import w0rm_decode_pkg::*;
;

  localparam int NUM_CYCLES    = 2000;
  localparam int DRAIN_TIMEOUT = 50;

  typedef struct packed {
    rf_ctrl_t     rf;
    alu_ctrl_t    alu;
    branch_ctrl_t branch;
    mem_ctrl_t    mem;
    wb_ctrl_t     wb;
  } decoded_t;

  logic         clk;
  logic         arst_n;
  logic         flush;
  logic         in_valid;
  inst_t        instruction;
  word_t        inst_addr;
  logic         out_ready;
  logic         in_ready;
  logic         out_valid;
  rf_ctrl_t     rf;
  alu_ctrl_t    alu;
  branch_ctrl_t branch;
  mem_ctrl_t    mem;
  wb_ctrl_t     wb;

  integer       seed;
  logic [31:0]  stim;
  int           wait_cycles;
  decoded_t     expected_q[$];
  decoded_t     actual;
  decoded_t     held_snapshot;
  logic         hold_pending;

  w0rm_decode uut (
    .clk         (clk),
    .arst_n      (arst_n),
    .flush       (flush),
    .in_valid    (in_valid),
    .instruction (instruction),
    .inst_addr   (inst_addr),
    .out_ready   (out_ready),
    .in_ready    (in_ready),
    .out_valid   (out_valid),
    .rf          (rf),
    .alu         (alu),
    .branch      (branch),
    .mem         (mem),
    .wb          (wb)
  );

  bind w0rm_decode decode_properties u_props (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rf        (rf),
    .alu       (alu),
    .branch    (branch),
    .mem       (mem),
    .wb        (wb)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Codes 0000 and 110x are consumed without output
  function automatic logic is_valid_code(input logic [3:0] code);
    return !(code == 4'b0000 || code[3:1] == 3'b110);
  endfunction

  function automatic decoded_t decode_ref(input inst_t inst, input word_t addr);
    decoded_t d;
    d = '0;
    casez (inst[15:12])
      4'b0001:
      begin
        d.rf.rd_addr   = inst[7:4];
        d.alu.ext_16   = inst[10];
        d.alu.opcode   = inst[11] ? 4'hb : 4'ha;
        d.wb.reg_write = 1'b1;
        d.wb.addr      = inst[7:4];
      end
      4'b010?:
      begin
        d.rf.rn_addr       = inst[3:0];
        d.rf.literal       = {24'd0, inst[7:0]};
        d.alu.op2_literal  = inst[12];
        d.alu.opcode       = 4'hf;
        d.wb.reg_write     = 1'b1;
        d.wb.addr          = inst[11:8];
      end
      4'b100?, 4'b101?:
      begin
        d.rf.rn_addr       = inst[3:0];
        d.alu.op2_literal  = !inst[12];
        d.alu.store_flags  = 4'hf;
        d.wb.reg_write     = 1'b1;
        if (inst[13])
        begin
          // Shift
          d.rf.rd_addr  = inst[11:8];
          d.rf.literal  = {27'd0, inst[4:0]};
          d.alu.opcode  = 4'hc + {2'b00, inst[7:6]};
          d.wb.addr     = inst[11:8];
        end
        else
        begin
          d.rf.rd_addr  = inst[7:4];
          d.rf.literal  = {28'd0, inst[3:0]};
          d.alu.opcode  = inst[11:8];
          d.wb.addr     = inst[7:4];
        end
      end
      4'b011?:
      begin
        d.rf.rd_addr      = inst[7:4];
        d.rf.rn_addr      = inst[11:8];
        d.rf.literal      = {28'd0, inst[3:0]};
        d.alu.op2_literal = 1'b1;
        d.alu.opcode      = 4'h8;
        d.mem.write       = inst[12];
        d.mem.read        = !inst[12];
        d.wb.reg_write    = !inst[12];
        d.wb.source       = 2'd1;
        d.wb.addr         = inst[11:8];
      end
      4'b1110:
      begin
        d.rf.rd_addr      = 4'd13;
        d.rf.rn_addr      = inst[3:0];
        d.rf.literal      = 32'd4;
        d.alu.op2_literal = 1'b1;
        d.alu.opcode      = inst[11] ? 4'h8 : 4'h9;
        d.mem.write       = !inst[11];
        d.mem.read        = inst[11];
        d.mem.is_pop      = inst[11];
        d.mem.addr_src    = inst[11] ? 2'd1 : 2'd0;
        d.wb.reg_write    = inst[11];
        d.wb.source       = 2'd1;
        d.wb.addr         = inst[3:0];
      end
      4'b001?, 4'b1111:
      begin
        d.rf.rn_addr       = inst[3:0];
        d.alu.opcode       = 4'hf;
        d.branch.is_branch = 1'b1;
        d.branch.base_addr = addr;
        d.wb.source        = 2'd2;
        d.wb.addr          = 4'd14;
        if (inst[15])
        begin
          d.rf.literal      = {{22{inst[9]}}, inst[9:0]};
          d.alu.op2_literal = !inst[11];
          d.wb.reg_write    = inst[10];
        end
        else
        begin
          d.rf.literal      = {{24{inst[7]}}, inst[7:0]};
          d.alu.op2_literal = !inst[12];
          d.branch.is_cond  = 1'b1;
          d.branch.code     = inst[10:8];
          d.wb.reg_write    = inst[11];
        end
      end
      default:
      begin
        d = '0;
      end
    endcase
    return d;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Stopping on first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] expected,
                             input logic [63:0] got);
    assert (got === expected)
    else
      report_error($sformatf("FAILED at %0t: %s expected %h, actual %h",
                             $time, name, expected, got));
  endtask

  task automatic check_outputs(input string tag, input decoded_t expected,
                               input decoded_t got);
    check_field({tag, "rf"}, 64'(expected.rf), 64'(got.rf));
    check_field({tag, "alu"}, 64'(expected.alu), 64'(got.alu));
    check_field({tag, "branch"}, 64'(expected.branch), 64'(got.branch));
    check_field({tag, "mem"}, 64'(expected.mem), 64'(got.mem));
    check_field({tag, "wb"}, 64'(expected.wb), 64'(got.wb));
  endtask

  // Sampled mid-cycle, where inputs and outputs are settled for the next edge
  always @(negedge clk)
  begin
    actual.rf     = rf;
    actual.alu    = alu;
    actual.branch = branch;
    actual.mem    = mem;
    actual.wb     = wb;
    if (!arst_n)
    begin
      check_field("out_valid in reset", 64'd0, 64'(out_valid));
      check_field("in_ready in reset", 64'd1, 64'(in_ready));
      hold_pending = 1'b0;
      expected_q.delete();
    end
    else
    begin
      assert (uut.u_props.fail_count == 0)
      else
        report_error("A bound handshake or control property failed");
      // One pending entry means one instruction presented
      check_field("out_valid", 64'(expected_q.size() != 0), 64'(out_valid));
      check_field("in_ready", 64'(expected_q.size() == 0 || out_ready), 64'(in_ready));
      if (hold_pending)
        check_outputs("held ", held_snapshot, actual);
      if (out_valid && out_ready)
        check_outputs("", expected_q.pop_front(), actual);
      hold_pending  = out_valid && !out_ready && !flush;
      held_snapshot = actual;
      // Flush drops both the held entry and anything taken on the same edge
      if (flush)
        expected_q.delete();
      else if (in_valid && in_ready && is_valid_code(instruction[15:12]))
        expected_q.push_back(decode_ref(instruction, inst_addr));
    end
  end

  initial
  begin
    seed        = 61;
    arst_n      = 1'b0;
    flush       = 1'b0;
    in_valid    = 1'b0;
    instruction = '0;
    inst_addr   = '0;
    out_ready   = 1'b0;
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;

    for (int i = 0; i < NUM_CYCLES; i++)
    begin
      @(posedge clk);
      #1;
      stim        = $random(seed);
      in_valid    = stim[1:0] != 2'b00;
      out_ready   = stim[3:2] != 2'b00;
      flush       = stim[9:5] == 5'd0;
      instruction = $random(seed);
      inst_addr   = $random(seed);
    end

    @(posedge clk);
    #1;
    in_valid  = 1'b0;
    flush     = 1'b0;
    out_ready = 1'b1;
    wait_cycles = 0;
    while (expected_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT)
    begin
      @(posedge clk);
      wait_cycles++;
    end
    @(negedge clk);
    #1;

    if (expected_q.size() == 0 && uut.u_props.fail_count == 0)
    begin
      $display("Everything OK");
      $finish;
    end
    else
    begin
      $display("Run ended with %0d instructions undelivered and %0d property failures",
               expected_q.size(), uut.u_props.fail_count);
      $display("Something failed");
      $fatal(1, "Run failed");
    end
  end

endmodule

`default_nettype wire
